//--- modbusPkg.sv
// ----------------------------------------
// Modbus RTU slave shared types
// Constants, codes and bus structs
// ----------------------------------------
package modbusPkg;

    localparam int WB_ADDR_WIDTH = 24;
    localparam int REG_WIDTH = 16;       // fixed by Modbus

    // staging store for write requests
    localparam int BUF_DEPTH = 128;
    localparam int BUF_PTR_WIDTH = 7;

    localparam int MAX_READ_QTY = 125;
    localparam int MAX_WRITE_QTY = 123;
    localparam int REG_SPACE = 65535;    // start plus quantity must stay within

    typedef enum logic [7:0] {
        READ_HOLDING   = 8'h03,
        WRITE_MULTIPLE = 8'h10
    } funcCode_e;

    typedef enum logic [7:0] {
        ILLEGAL_FUNCTION = 8'h01,
        ILLEGAL_ADDRESS  = 8'h02,
        ILLEGAL_VALUE    = 8'h03         // bad quantity or byte count
    } exceptionCode_e;

    // byte strobe from the UART receiver
    typedef struct packed {
        logic       valid;
        logic       parityError;
        logic [7:0] data;
    } rxByte_t;

    typedef struct packed {
        funcCode_e      func;
        logic           isException;
        exceptionCode_e exception;
        logic [15:0]    startAddr;
        logic [8:0]     quantity;
    } request_t;

    typedef struct packed {
        logic                     cyc;
        logic                     stb;
        logic                     we;
        logic [WB_ADDR_WIDTH-1:0] adr;
        logic [REG_WIDTH-1:0]     dat;
    } wbMaster_t;

endpackage

//--- crc16.sv
// ----------------------------------------
// Modbus CRC-16, one byte per cycle
// ----------------------------------------
`timescale 1ns/1ps

module crc16 (
    input  logic        clk,
    input  logic        rst,
    input  logic        clear,
    input  logic        en,
    input  logic [7:0]  data,
    output logic [15:0] crc
);

    // reflected polynomial, lsb first
    function automatic logic [15:0] nextCrc(input logic [15:0] cur, input logic [7:0] d);
        logic [15:0] r;
        r = cur ^ {8'h00, d};
        for (int i = 0; i < 8; i++) begin
            r = r[0] ? ((r >> 1) ^ 16'hA001) : (r >> 1);
        end
        return r;
    endfunction

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            crc <= 16'hFFFF;
        end else if (en) begin
            crc <= nextCrc(crc, data);
        end
    end

endmodule

//--- frameReceiver.sv
// ----------------------------------------
// Modbus request parser
// Checks fields and CRC, stages write data
// ----------------------------------------
`timescale 1ns/1ps

module frameReceiver import modbusPkg::*; #(
    parameter logic [7:0] STATION_ADDRESS = 8'h37
) (
    input  logic                     clk,
    input  logic                     rst,
    input  rxByte_t                  rx,
    input  logic                     silence,
    input  logic                     busy,
    output request_t                 req,
    output logic                     reqValid,
    output logic                     bufWe,
    output logic [BUF_PTR_WIDTH-1:0] bufWaddr,
    output logic [REG_WIDTH-1:0]     bufWdata
);

    typedef enum logic [3:0] {
        RX_ADDR,
        RX_FUNC,
        RX_START_HI,
        RX_START_LO,
        RX_QTY_HI,
        RX_QTY_LO,
        RX_BYTE_COUNT,
        RX_DATA_HI,
        RX_DATA_LO,
        RX_CRC_LO,
        RX_CRC_HI,
        RX_WAIT
    } rxState_e;

    rxState_e state;
    logic [15:0] qty;
    logic [7:0] dataHi;
    logic [7:0] crcLo;
    logic [BUF_PTR_WIDTH-1:0] wrPtr;
    logic [15:0] crc;
    logic accept;
    logic [15:0] rxQty;
    logic readQtyBad;
    logic writeQtyBad;
    logic countBad;
    logic readRangeBad;
    logic writeRangeBad;

    assign accept = rx.valid && !silence && !rx.parityError;
    assign rxQty = {qty[15:8], rx.data};   // quantity as its low byte arrives

    assign readQtyBad = rxQty == 16'd0 || rxQty > 16'(MAX_READ_QTY);
    assign writeQtyBad = qty == 16'd0 || qty > 16'(MAX_WRITE_QTY);
    assign countBad = {qty, 1'b0} != {9'b0, rx.data};
    assign readRangeBad = {1'b0, req.startAddr} + {1'b0, rxQty} > 17'(REG_SPACE);
    assign writeRangeBad = {1'b0, req.startAddr} + {1'b0, qty} > 17'(REG_SPACE);

    // one word per data byte pair
    assign bufWe = accept && state == RX_DATA_LO;
    assign bufWaddr = wrPtr;
    assign bufWdata = {dataHi, rx.data};

    // CRC bytes themselves are not accumulated
    crc16 i_crc (
        .clk  (clk),
        .rst  (rst),
        .clear(silence),
        .en   (accept && state != RX_CRC_LO && state != RX_CRC_HI && state != RX_WAIT),
        .data (rx.data),
        .crc  (crc)
    );

    always_ff @(posedge clk) begin
        reqValid <= 1'b0;
        if (rst) begin
            state <= RX_ADDR;
        end else if (silence) begin
            state <= RX_ADDR;
        end else if (rx.valid && rx.parityError) begin
            state <= RX_WAIT;
        end else if (accept) begin
            case (state)
                RX_ADDR: begin
                    // frames arriving during a response are ignored
                    state <= (rx.data == STATION_ADDRESS && !busy) ? RX_FUNC : RX_WAIT;
                end
                RX_FUNC: begin
                    req.func <= funcCode_e'(rx.data);
                    req.isException <= 1'b0;
                    if (rx.data == READ_HOLDING || rx.data == WRITE_MULTIPLE) begin
                        state <= RX_START_HI;
                    end else begin
                        req.isException <= 1'b1;
                        req.exception <= ILLEGAL_FUNCTION;
                        reqValid <= 1'b1;
                        state <= RX_WAIT;
                    end
                end
                RX_START_HI: begin
                    req.startAddr[15:8] <= rx.data;
                    state <= RX_START_LO;
                end
                RX_START_LO: begin
                    req.startAddr[7:0] <= rx.data;
                    state <= RX_QTY_HI;
                end
                RX_QTY_HI: begin
                    qty[15:8] <= rx.data;
                    state <= RX_QTY_LO;
                end
                RX_QTY_LO: begin
                    qty[7:0] <= rx.data;
                    req.quantity <= rxQty[8:0];
                    if (req.func == WRITE_MULTIPLE) begin
                        state <= RX_BYTE_COUNT;
                    end else if (readQtyBad || readRangeBad) begin
                        req.isException <= 1'b1;
                        req.exception <= readQtyBad ? ILLEGAL_VALUE : ILLEGAL_ADDRESS;
                        reqValid <= 1'b1;
                        state <= RX_WAIT;
                    end else begin
                        state <= RX_CRC_LO;
                    end
                end
                RX_BYTE_COUNT: begin
                    wrPtr <= '0;
                    if (writeQtyBad || countBad || writeRangeBad) begin
                        req.isException <= 1'b1;
                        req.exception <= (writeQtyBad || countBad) ? ILLEGAL_VALUE
                                                                   : ILLEGAL_ADDRESS;
                        reqValid <= 1'b1;
                        state <= RX_WAIT;
                    end else begin
                        state <= RX_DATA_HI;
                    end
                end
                RX_DATA_HI: begin
                    dataHi <= rx.data;
                    state <= RX_DATA_LO;
                end
                RX_DATA_LO: begin
                    wrPtr <= wrPtr + 1'b1;
                    state <= (16'(wrPtr) == qty - 16'd1) ? RX_CRC_LO : RX_DATA_HI;
                end
                RX_CRC_LO: begin
                    crcLo <= rx.data;
                    state <= RX_CRC_HI;
                end
                RX_CRC_HI: begin
                    reqValid <= {rx.data, crcLo} == crc;   // bad CRC drops silently
                    state <= RX_WAIT;
                end
                default: state <= RX_WAIT;             // wait for silence
            endcase
        end
    end

    // the responder never sees a second request mid response
    assert property (@(posedge clk) disable iff (rst) !(reqValid && busy));

endmodule

//--- regBuffer.sv
// ----------------------------------------
// Write request register store
// ----------------------------------------
`timescale 1ns/1ps

module regBuffer import modbusPkg::*; (
    input  logic                     clk,
    input  logic                     we,
    input  logic [BUF_PTR_WIDTH-1:0] waddr,
    input  logic [REG_WIDTH-1:0]     wdata,
    input  logic [BUF_PTR_WIDTH-1:0] raddr,
    output logic [REG_WIDTH-1:0]     rdata
);

    logic [REG_WIDTH-1:0] mem [BUF_DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
        rdata <= mem[raddr];   // one cycle read latency
    end

endmodule

//--- responder.sv
// ----------------------------------------
// Modbus responder
// Wishbone cycles, response bytes on credits
// ----------------------------------------
`timescale 1ns/1ps

module responder import modbusPkg::*; #(
    parameter logic [7:0]               STATION_ADDRESS = 8'h37,
    parameter logic [WB_ADDR_WIDTH-1:0] REG_BASE        = 24'hA00000,
    parameter int                       TX_CREDITS      = 4
) (
    input  logic                     clk,
    input  logic                     rst,
    input  request_t                 req,
    input  logic                     reqValid,
    output logic                     busy,
    output wbMaster_t                wb,
    input  logic [REG_WIDTH-1:0]     wbDatI,
    input  logic                     wbAckI,
    output logic [BUF_PTR_WIDTH-1:0] bufRaddr,
    input  logic [REG_WIDTH-1:0]     bufRdata,
    input  logic                     txCredit,
    output logic                     txValid,
    output logic [7:0]               txData
);

    localparam int CREDIT_WIDTH = $clog2(TX_CREDITS + 1);

    typedef enum logic [4:0] {
        TX_IDLE, TX_WB_LOAD, TX_WB_WRITE, TX_WB_WRITE_ACK,
        TX_STATION, TX_FUNC, TX_EXC, TX_BYTE_COUNT,
        TX_ADDR_HI, TX_ADDR_LO, TX_QTY_HI, TX_QTY_LO,
        TX_WB_READ, TX_WB_READ_ACK, TX_DATA_HI, TX_DATA_LO,
        TX_CRC_LO, TX_CRC_HI
    } txState_e;

    txState_e state;
    request_t cur;
    logic [BUF_PTR_WIDTH-1:0] wordIdx;
    logic [REG_WIDTH-1:0] readData;
    logic [CREDIT_WIDTH-1:0] credits;
    logic [15:0] crc;
    logic sending;
    logic lastWord;
    logic [WB_ADDR_WIDTH-1:0] wordAdr;

    assign busy = state != TX_IDLE;
    assign bufRaddr = wordIdx;
    assign lastWord = {2'b00, wordIdx} == cur.quantity;   // index already past issued word
    assign wordAdr = REG_BASE + WB_ADDR_WIDTH'(cur.startAddr) + WB_ADDR_WIDTH'(wordIdx);
    assign txValid = sending && credits != '0;

    always_comb begin
        sending = 1'b1;
        case (state)
            TX_STATION:    txData = STATION_ADDRESS;
            TX_FUNC:       txData = cur.isException ? {1'b1, cur.func[6:0]} : cur.func;
            TX_EXC:        txData = cur.exception;
            TX_BYTE_COUNT: txData = {cur.quantity[6:0], 1'b0};
            TX_ADDR_HI:    txData = cur.startAddr[15:8];
            TX_ADDR_LO:    txData = cur.startAddr[7:0];
            TX_QTY_HI:     txData = {7'b0, cur.quantity[8]};
            TX_QTY_LO:     txData = cur.quantity[7:0];
            TX_DATA_HI:    txData = readData[15:8];
            TX_DATA_LO:    txData = readData[7:0];
            TX_CRC_LO:     txData = crc[7:0];
            TX_CRC_HI:     txData = crc[15:8];
            default: begin
                txData = 8'h00;
                sending = 1'b0;
            end
        endcase
    end

    crc16 i_crc (
        .clk  (clk),
        .rst  (rst),
        .clear(state == TX_IDLE),
        .en   (txValid && state != TX_CRC_LO && state != TX_CRC_HI),
        .data (txData),
        .crc  (crc)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            credits <= CREDIT_WIDTH'(TX_CREDITS);
        end else begin
            credits <= credits + CREDIT_WIDTH'(txCredit) - CREDIT_WIDTH'(txValid);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= TX_IDLE;
            wb.cyc <= 1'b0;
            wb.stb <= 1'b0;
        end else begin
            case (state)
                TX_IDLE: if (reqValid) begin
                    cur <= req;
                    wordIdx <= '0;
                    state <= (req.isException || req.func == READ_HOLDING) ? TX_STATION
                                                                           : TX_WB_LOAD;
                end
                TX_WB_LOAD: state <= TX_WB_WRITE;   // buffer read latency
                TX_WB_WRITE: begin
                    wb.cyc <= 1'b1;
                    wb.stb <= 1'b1;
                    wb.we <= 1'b1;
                    wb.adr <= wordAdr;
                    wb.dat <= bufRdata;
                    wordIdx <= wordIdx + 1'b1;
                    state <= TX_WB_WRITE_ACK;
                end
                TX_WB_WRITE_ACK: if (wbAckI) begin
                    wb.cyc <= 1'b0;
                    wb.stb <= 1'b0;
                    state <= lastWord ? TX_STATION : TX_WB_WRITE;
                end
                TX_STATION: if (txValid) state <= TX_FUNC;
                TX_FUNC: if (txValid) begin
                    if (cur.isException) state <= TX_EXC;
                    else if (cur.func == READ_HOLDING) state <= TX_BYTE_COUNT;
                    else state <= TX_ADDR_HI;
                end
                TX_EXC: if (txValid) state <= TX_CRC_LO;
                TX_BYTE_COUNT: if (txValid) state <= TX_WB_READ;
                TX_ADDR_HI: if (txValid) state <= TX_ADDR_LO;
                TX_ADDR_LO: if (txValid) state <= TX_QTY_HI;
                TX_QTY_HI: if (txValid) state <= TX_QTY_LO;
                TX_QTY_LO: if (txValid) state <= TX_CRC_LO;
                TX_WB_READ: begin
                    wb.cyc <= 1'b1;
                    wb.stb <= 1'b1;
                    wb.we <= 1'b0;
                    wb.adr <= wordAdr;
                    wordIdx <= wordIdx + 1'b1;
                    state <= TX_WB_READ_ACK;
                end
                TX_WB_READ_ACK: if (wbAckI) begin
                    readData <= wbDatI;
                    wb.cyc <= 1'b0;
                    wb.stb <= 1'b0;
                    state <= TX_DATA_HI;
                end
                TX_DATA_HI: if (txValid) state <= TX_DATA_LO;
                TX_DATA_LO: if (txValid) state <= lastWord ? TX_CRC_LO : TX_WB_READ;
                TX_CRC_LO: if (txValid) state <= TX_CRC_HI;
                TX_CRC_HI: if (txValid) state <= TX_IDLE;
                default: state <= TX_IDLE;
            endcase
        end
    end

    // a starved byte waits in place until a credit returns
    assert property (@(posedge clk) disable iff (rst)
        sending && !txValid |=> $stable(state) && $stable(txData));
    assert property (@(posedge clk) disable iff (rst) credits <= CREDIT_WIDTH'(TX_CREDITS));
    assert property (@(posedge clk) disable iff (rst) wb.stb |-> wb.cyc);
    // request held steady until the slave answers
    assert property (@(posedge clk) disable iff (rst)
        wb.stb && !wbAckI |=> wb.stb && $stable(wb.adr) && $stable(wb.we));

endmodule

//--- modbusSlave.sv
// ----------------------------------------
// Modbus RTU slave to Wishbone bridge
// ----------------------------------------
`timescale 1ns/1ps

module modbusSlave import modbusPkg::*; #(
    parameter logic [7:0]               STATION_ADDRESS = 8'h37,
    parameter logic [WB_ADDR_WIDTH-1:0] REG_BASE        = 24'hA00000,
    parameter int                       TX_CREDITS      = 4
) (
    input  logic                 clk,
    input  logic                 rst,
    input  rxByte_t              rx,
    input  logic                 silence,
    output wbMaster_t            wb,
    input  logic [REG_WIDTH-1:0] wbDatI,
    input  logic                 wbAckI,
    input  logic                 txCredit,
    output logic                 txValid,
    output logic [7:0]           txData
);

    request_t req;
    logic reqValid;
    logic busy;
    logic bufWe;
    logic [BUF_PTR_WIDTH-1:0] bufWaddr;
    logic [REG_WIDTH-1:0] bufWdata;
    logic [BUF_PTR_WIDTH-1:0] bufRaddr;
    logic [REG_WIDTH-1:0] bufRdata;

    frameReceiver #(
        .STATION_ADDRESS(STATION_ADDRESS)
    ) i_receiver (
        .clk     (clk),
        .rst     (rst),
        .rx      (rx),
        .silence (silence),
        .busy    (busy),
        .req     (req),
        .reqValid(reqValid),
        .bufWe   (bufWe),
        .bufWaddr(bufWaddr),
        .bufWdata(bufWdata)
    );

    regBuffer i_buffer (
        .clk  (clk),
        .we   (bufWe),
        .waddr(bufWaddr),
        .wdata(bufWdata),
        .raddr(bufRaddr),
        .rdata(bufRdata)
    );

    responder #(
        .STATION_ADDRESS(STATION_ADDRESS),
        .REG_BASE       (REG_BASE),
        .TX_CREDITS     (TX_CREDITS)
    ) i_responder (
        .clk     (clk),
        .rst     (rst),
        .req     (req),
        .reqValid(reqValid),
        .busy    (busy),
        .wb      (wb),
        .wbDatI  (wbDatI),
        .wbAckI  (wbAckI),
        .bufRaddr(bufRaddr),
        .bufRdata(bufRdata),
        .txCredit(txCredit),
        .txValid (txValid),
        .txData  (txData)
    );

endmodule

//--- tbFrames.svh
// ----------------------------------------
// Modbus frame builders, CRC and the
// expected response model for the testbench
// ----------------------------------------
`ifndef TB_FRAMES_SVH
`define TB_FRAMES_SVH

// bit serial form, preset FFFF, reflected poly A001
function automatic logic [15:0] crcOfQueue(input logic [7:0] q[$]);
    logic [15:0] c;
    logic fb;
    c = 16'hFFFF;
    foreach (q[n]) begin
        for (int i = 0; i < 8; i++) begin
            fb = c[0] ^ q[n][i];
            c = c >> 1;
            if (fb) c = c ^ 16'hA001;
        end
    end
    return c;
endfunction

function automatic logic [15:0] regValue(input logic [15:0] addr);
    return refMem.exists(addr) ? refMem[addr] : addr ^ 16'h5A5A;   // preload pattern
endfunction

task automatic addRequestWord(input logic [15:0] w);
    reqBytes.push_back(w[15:8]);
    reqBytes.push_back(w[7:0]);
endtask

task automatic expectWord(input logic [15:0] w);
    txExpQ.push_back(w[15:8]);
    txExpQ.push_back(w[7:0]);
endtask

// CRC travels low byte first
task automatic appendRequestCrc();
    logic [15:0] c;
    c = crcOfQueue(reqBytes);
    addRequestWord({c[7:0], c[15:8]});
endtask

task automatic closeResponse();
    logic [15:0] c;
    c = crcOfQueue(txExpQ);
    expectWord({c[7:0], c[15:8]});
endtask

task automatic expectException(input logic [7:0] func, input logic [7:0] code);
    txExpQ.delete();
    txExpQ.push_back(STATION);
    txExpQ.push_back(func | 8'h80);
    txExpQ.push_back(code);
    closeResponse();
endtask

task automatic buildRead(input logic [15:0] start, input logic [15:0] qty);
    reqBytes.delete();
    reqBytes.push_back(STATION);
    reqBytes.push_back(8'h03);
    addRequestWord(start);
    addRequestWord(qty);
    appendRequestCrc();
    if (qty == 16'd0 || qty > 16'd125) begin
        expectException(8'h03, 8'h03);
    end else if (32'(start) + 32'(qty) > 32'd65535) begin
        expectException(8'h03, 8'h02);
    end else begin
        txExpQ.delete();
        txExpQ.push_back(STATION);
        txExpQ.push_back(8'h03);
        txExpQ.push_back(8'(qty * 16'd2));
        for (int i = 0; i < int'(qty); i++) begin
            expectWord(regValue(start + 16'(i)));
        end
        closeResponse();
    end
endtask

task automatic buildWrite(input logic [15:0] start, input logic [15:0] qty,
                          input logic [7:0] count);
    logic [15:0] words[$];
    reqBytes.delete();
    reqBytes.push_back(STATION);
    reqBytes.push_back(8'h10);
    addRequestWord(start);
    addRequestWord(qty);
    reqBytes.push_back(count);
    for (int i = 0; i < int'(qty); i++) begin
        words.push_back(16'($random(stimSeed)));
        addRequestWord(words[i]);
    end
    appendRequestCrc();
    if (qty == 16'd0 || qty > 16'd123 || 16'(count) != qty * 16'd2) begin
        expectException(8'h10, 8'h03);
    end else if (32'(start) + 32'(qty) > 32'd65535) begin
        expectException(8'h10, 8'h02);
    end else begin
        for (int i = 0; i < int'(qty); i++) begin
            wbExpQ.push_back({REG_BASE + 24'(start) + 24'(i), words[i]});
            refMem[start + 16'(i)] = words[i];
        end
        txExpQ.delete();
        txExpQ.push_back(STATION);
        txExpQ.push_back(8'h10);
        expectWord(start);   // echo of start and quantity
        expectWord(qty);
        closeResponse();
    end
endtask

`endif

//--- tbModbusSlave.sv
// ----------------------------------------
// Modbus slave testbench
// Wishbone memory, credit return, checks
// ----------------------------------------
`timescale 1ns/1ps

module tbModbusSlave import modbusPkg::*; ();

    localparam logic [7:0] STATION = 8'h37;
    localparam logic [WB_ADDR_WIDTH-1:0] REG_BASE = 24'hA00000;
    localparam int TX_CREDITS = 4;
    localparam int TIMEOUT_CYCLES = 20000;   // about four times the test length
    localparam logic [31:0] SEED = 32'h3245_594d;

    logic clk = 1'b0;
    logic rst;
    rxByte_t rx;
    logic silence;
    wbMaster_t wb;
    logic [REG_WIDTH-1:0] wbDatI;
    logic wbAckI;
    logic txCredit;
    logic txValid;
    logic [7:0] txData;

    integer stimSeed;
    integer wbSeed;
    integer creditSeed;
    logic [7:0] reqBytes[$];
    logic [7:0] txExpQ[$];
    logic [39:0] wbExpQ[$];   // {adr, dat}
    logic [15:0] refMem[logic [15:0]];
    logic [15:0] wbMem[logic [WB_ADDR_WIDTH-1:0]];
    string testName = "reset";
    logic expectActivity;
    logic starve;
    int avail;
    int owed;
    int ackWait;
    int creditWait;
    int cycleCount;
    int startLen;

    `include "tbFrames.svh"

    always #4 clk = ~clk;

    modbusSlave #(
        .STATION_ADDRESS(STATION),
        .REG_BASE       (REG_BASE),
        .TX_CREDITS     (TX_CREDITS)
    ) i_dut (
        .clk(clk), .rst(rst), .rx(rx), .silence(silence),
        .wb(wb), .wbDatI(wbDatI), .wbAckI(wbAckI),
        .txCredit(txCredit), .txValid(txValid), .txData(txData)
    );

    task automatic reportMismatch(input string what, input logic [39:0] expected,
                                  input logic [39:0] actual);
        $display("Fail %s, %s: expected %0h, actual %0h", testName, what, expected, actual);
        $display("RESULT: FAIL");
        $fatal(1, "value mismatch");
    endtask

    task automatic reportError(input string why);
        $display("Error in %s: %s", testName, why);
        $display("RESULT: FAIL");
        $fatal(1, "check failed");
    endtask

    function automatic logic [15:0] memRead(input logic [WB_ADDR_WIDTH-1:0] a);
        return wbMem.exists(a) ? wbMem[a] : a[15:0] ^ 16'h5A5A;
    endfunction

    // one byte per strobe, random gaps, then a silence gap
    task automatic sendFrame(input int parityAt);
        foreach (reqBytes[n]) begin
            @(posedge clk);
            rx <= '{valid: 1'b1, parityError: (n == parityAt), data: reqBytes[n]};
            @(posedge clk);
            rx <= '0;
            repeat ($random(stimSeed) & 3) @(posedge clk);
        end
        repeat (2) @(posedge clk);
        silence <= 1'b1;
        repeat (4) @(posedge clk);
        silence <= 1'b0;
    endtask

    task automatic startCase(input string name, input int parityAt);
        testName = name;
        expectActivity <= txExpQ.size() > 0;
        sendFrame(parityAt);
    endtask

    task automatic finishCase();
        while (txExpQ.size() > 0) @(posedge clk);
        repeat (20) @(posedge clk);   // room for stray activity
        assert (wbExpQ.size() == 0)
            else reportMismatch("pending writes", 40'd0, 40'(wbExpQ.size()));
        expectActivity <= 1'b0;
    endtask

    // Wishbone slave memory with random ack delay
    always @(posedge clk) begin
        wbAckI <= 1'b0;
        assert (!wb.cyc || expectActivity) else reportError("Wishbone cycle on a dropped frame");
        if (wb.cyc && wb.stb && !wbAckI) begin
            if (ackWait > 0) begin
                ackWait--;
            end else begin
                ackWait = $random(wbSeed) & 3;
                wbAckI <= 1'b1;
                if (wb.we) begin
                    assert (wbExpQ.size() > 0) else reportError("Wishbone write not expected");
                    assert (wb.adr == wbExpQ[0][39:16])
                        else reportMismatch("write address", wbExpQ[0][39:16], wb.adr);
                    assert (wb.dat == wbExpQ[0][15:0])
                        else reportMismatch("write data", wbExpQ[0][15:0], wb.dat);
                    void'(wbExpQ.pop_front());
                    wbMem[wb.adr] = wb.dat;
                end else begin
                    wbDatI <= memRead(wb.adr);
                end
            end
        end
    end

    // credit bookkeeping and delayed return
    always @(posedge clk) begin
        txCredit <= 1'b0;
        if (rst) begin
            avail = TX_CREDITS;
            owed = 0;
        end else begin
            if (txValid) begin
                assert (avail > 0) else reportError("byte sent with no credit left");
                avail--;
                owed++;
            end
            if (txCredit) avail++;
            if (owed > 0 && !starve) begin
                if (creditWait > 0) begin
                    creditWait--;
                end else begin
                    txCredit <= 1'b1;
                    owed--;
                    creditWait = $random(creditSeed) & 3;
                end
            end
        end
    end

    always @(posedge clk) begin
        if (!rst && txValid) begin
            assert (txExpQ.size() > 0) else reportError("response byte with none expected");
            assert (txData == txExpQ[0]) else reportMismatch("response byte", txExpQ[0], txData);
            void'(txExpQ.pop_front());
        end
    end

    initial begin
        for (cycleCount = 0; cycleCount < TIMEOUT_CYCLES; cycleCount++) begin
            @(posedge clk);
        end
        $display("Timeout after %0d cycles in %s", cycleCount, testName);
        $display("RESULT: FAIL");
        $fatal(1, "timeout");
    end

    initial begin
        stimSeed = SEED;
        wbSeed = SEED ^ 32'h1;
        creditSeed = SEED ^ 32'h2;
        rst = 1'b1;
        silence = 1'b1;
        rx = '0;
        wbAckI = 1'b0;
        wbDatI = '0;
        txCredit = 1'b0;
        starve = 1'b0;
        expectActivity = 1'b0;
        ackWait = 0;
        creditWait = 0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        repeat (4) @(posedge clk);
        silence <= 1'b0;

        buildRead(16'h0010, 16'd1);
        startCase("read 1", -1);
        finishCase();
        buildRead(16'h1234, 16'd10);
        startCase("read 10", -1);
        finishCase();
        buildRead(16'h0200, 16'd125);
        startCase("read 125", -1);
        finishCase();
        buildWrite(16'h0100, 16'd5, 8'd10);
        startCase("write 5", -1);
        finishCase();
        buildRead(16'h0100, 16'd5);
        startCase("read back 5", -1);
        finishCase();
        buildWrite(16'h2000, 16'd123, 8'd246);
        startCase("write 123", -1);
        finishCase();
        buildRead(16'h2000, 16'd123);
        startCase("read back 123", -1);
        finishCase();

        // exceptions
        reqBytes.delete();
        reqBytes.push_back(STATION);
        reqBytes.push_back(8'h05);
        addRequestWord(16'h0000);
        addRequestWord(16'h0001);
        appendRequestCrc();
        expectException(8'h05, 8'h01);
        startCase("function 05", -1);
        finishCase();
        buildRead(16'h0000, 16'd0);
        startCase("read quantity 0", -1);
        finishCase();
        buildRead(16'h0000, 16'd126);
        startCase("read quantity 126", -1);
        finishCase();
        buildWrite(16'h0300, 16'd3, 8'd5);
        startCase("byte count mismatch", -1);
        finishCase();
        buildRead(16'hFFF0, 16'd32);
        startCase("address range", -1);
        finishCase();

        // frames that must be dropped
        buildRead(16'h0010, 16'd2);
        txExpQ.delete();
        void'(reqBytes.pop_back());
        void'(reqBytes.pop_back());
        reqBytes[0] = 8'h11;
        appendRequestCrc();
        startCase("wrong station", -1);
        finishCase();
        buildRead(16'h0010, 16'd2);
        txExpQ.delete();
        startCase("parity error", 3);
        finishCase();
        buildRead(16'h0010, 16'd2);
        txExpQ.delete();
        reqBytes[7] = reqBytes[7] ^ 8'h01;
        startCase("bad CRC", -1);
        finishCase();

        // credits held back, then released
        buildRead(16'h0400, 16'd125);
        startLen = txExpQ.size();
        starve <= 1'b1;
        startCase("starved read 125", -1);
        repeat (400) @(posedge clk);
        assert (startLen - txExpQ.size() <= TX_CREDITS)
            else reportMismatch("bytes while starved", 40'(TX_CREDITS),
                                40'(startLen - txExpQ.size()));
        starve <= 1'b0;
        finishCase();

        $display("RESULT: PASS");
        $finish;
    end

endmodule

//--- flist.f
+incdir+.
modbusPkg.sv
crc16.sv
frameReceiver.sv
regBuffer.sv
responder.sv
modbusSlave.sv
tbModbusSlave.sv

//--- Makefile
SIM        = verilator
TOP        = tbModbusSlave
FLIST      = flist.f
BUILD      = obj_dir
SIM_FLAGS  = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP)

clean:
	rm -rf $(BUILD)
